/* logic/layer_ctrl_pkg.sv */
package layer_ctrl_pkg;

	// Shape of this hidden layer
	localparam int P = 16; // Neurons in the layer
	localparam int Z = 4; // Parallel memories in one collection
	localparam int FO = 2; // Fan-out per neuron and also the number of parts per collection
	localparam int L = 3; // Layers in the network
	localparam int H = 1; // Index of this layer

	// Derived schedule figures
	localparam int WRITE_CLKS = P / Z * FO; // Clocks in a cycle that carry data
	localparam int CPC = WRITE_CLKS + 2; // Two extra clocks cover the memory pipeline
	localparam int ACT_COLL = 2 * (L - H) - 1; // Activation and sigmoid-prime collections
	localparam int DM_COLL = 2; // Delta memory always ping-pongs between two collections

	// Field widths
	localparam int ADDR_W = $clog2(P / Z); // Each memory holds P/Z cells
	localparam int CIDX_W = $clog2(CPC);
	localparam int MIDX_W = $clog2(P); // A memory index names one neuron
	localparam int WADDR_W = $clog2(WRITE_CLKS); // One weight cell per data clock
	localparam int PART_W = $clog2(FO); // Low cycle index bits that pick a part

	typedef logic [CIDX_W-1:0] cidx_t; // Position inside the cycle
	typedef logic [ADDR_W-1:0] addr_t; // Cell address of one activation or delta memory
	typedef logic [WADDR_W-1:0] waddr_t; // Cell address of one weight memory
	typedef logic [MIDX_W-1:0] midx_t; // Upper bits give the cell and lower bits the memory
	typedef logic [$clog2(ACT_COLL)-1:0] act_pt_t; // Selects one activation collection

endpackage

/* logic/ctrl_ifs.sv */
`timescale 1ns/1ps

// Cycle position as seen by every controller
interface cycle_if;
	import layer_ctrl_pkg::*;

	cidx_t cycle_index; // Current clock inside the cycle
	cidx_t cycle_index_d1; // Used by the read-modify-write path of the delta memory
	cidx_t cycle_index_d2; // Used for activation writes which land two clocks late
	logic cycle_start; // High on the last clock so registers step on the wrap edge

	modport source (
		output cycle_index,
		output cycle_index_d1,
		output cycle_index_d2,
		output cycle_start
	);

	modport sink (
		input cycle_index,
		input cycle_index_d1,
		input cycle_index_d2,
		input cycle_start
	);
endinterface

// Collection pointers shared by the memory controllers
interface ptr_if;
	import layer_ctrl_pkg::*;

	act_pt_t rff_pt; // Collection read for the next layer feed-forward
	act_pt_t w_pt; // Collection being filled by the previous layer
	act_pt_t rup_pt; // Collection read for the update and for sigmoid prime
	logic d_rbp_pt; // Delta collection read for back-propagation to the previous layer

	modport source (output rff_pt, output w_pt, output rup_pt, output d_rbp_pt);

	modport sink (input rff_pt, input w_pt, input rup_pt, input d_rbp_pt);
endinterface

/* logic/stage_delay.sv */
`timescale 1ns/1ps

module stage_delay #(
	parameter type T = logic,
	parameter int DEPTH = 1
) (
	input logic clk,
	input logic reset_i,
	input T d_i,
	output T q_o
);

	T pipe_q [DEPTH]; // One entry per clock of delay

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < DEPTH; i++)
				pipe_q[i] <= '0; // All stages start empty
		end
		else
		begin
			pipe_q[0] <= d_i;
			for (int i = 1; i < DEPTH; i++)
				pipe_q[i] <= pipe_q[i-1]; // Every stage moves one step per clock
		end
	end

	assign q_o = pipe_q[DEPTH-1]; // Oldest entry leaves the line
endmodule

/* logic/cycle_sequencer.sv */
`timescale 1ns/1ps

module cycle_sequencer (
	input logic clk,
	input logic reset_i,
	cycle_if.source cyc,
	output layer_ctrl_pkg::cidx_t cycle_index_o
);
	import layer_ctrl_pkg::*;

	cidx_t count_q; // Free running position inside the cycle
	cidx_t count_d1;
	cidx_t count_d2;
	logic last_clk; // Final clock of the cycle

	assign last_clk = (count_q == cidx_t'(CPC - 1));

	// Wraps to zero after CPC clocks and never stalls
	always_ff @(posedge clk)
	begin
		if (reset_i)
			count_q <= '0;
		else if (last_clk)
			count_q <= '0;
		else
			count_q <= count_q + cidx_t'(1);
	end

	// Two single-clock stages so the d1 copy can be tapped on the way
	stage_delay #(.T(cidx_t), .DEPTH(1)) u_delay_d1 (
		.clk(clk),
		.reset_i(reset_i),
		.d_i(count_q),
		.q_o(count_d1)
	);

	stage_delay #(.T(cidx_t), .DEPTH(1)) u_delay_d2 (
		.clk(clk),
		.reset_i(reset_i),
		.d_i(count_d1),
		.q_o(count_d2)
	);

	assign cyc.cycle_index = count_q;
	assign cyc.cycle_index_d1 = count_d1;
	assign cyc.cycle_index_d2 = count_d2;
	assign cyc.cycle_start = last_clk; // Pointers advance on the edge that wraps the count
	assign cycle_index_o = count_q;

	// The counter must wrap before it reaches CPC or the enable windows break
	a_index_in_range: assert property (@(posedge clk) disable iff (reset_i)
		count_q < cidx_t'(CPC))
		else $error("Cycle index left its range");
endmodule

/* logic/collection_pointers.sv */
`timescale 1ns/1ps

module collection_pointers (
	input logic clk,
	input logic reset_i,
	cycle_if.sink cyc,
	ptr_if.source ptr,
	output layer_ctrl_pkg::act_pt_t rff_pt_o,
	output layer_ctrl_pkg::act_pt_t rup_pt_o
);
	import layer_ctrl_pkg::*;

	act_pt_t rff_q; // Feed-forward read collection
	act_pt_t w_q; // Write collection which always sits one ahead of rff
	act_pt_t rup_q; // Update read collection two ahead of rff
	logic d_rbp_q; // Delta ping-pong pointer

	// Next collection with wrap at ACT_COLL
	function automatic act_pt_t next_pt(input act_pt_t pt);
		if (pt == act_pt_t'(ACT_COLL - 1))
			return '0;
		return pt + act_pt_t'(1);
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			rff_q <= act_pt_t'(0);
			w_q <= act_pt_t'(1);
			rup_q <= act_pt_t'(2);
			d_rbp_q <= 1'b0;
		end
		else if (cyc.cycle_start)
		begin
			rff_q <= next_pt(rff_q); // All three rotate together so their spacing holds
			w_q <= next_pt(w_q);
			rup_q <= next_pt(rup_q);
			d_rbp_q <= ~d_rbp_q; // Read and read-modify-write roles swap each cycle
		end
	end

	// Memory reads take one clock so the downstream read multiplexers need late copies
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			rff_pt_o <= '0;
			rup_pt_o <= '0;
		end
		else
		begin
			rff_pt_o <= rff_q;
			rup_pt_o <= rup_q;
		end
	end

	assign ptr.rff_pt = rff_q;
	assign ptr.w_pt = w_q;
	assign ptr.rup_pt = rup_q;
	assign ptr.d_rbp_pt = d_rbp_q;

	// A collection being written must never be read by feed-forward or update
	a_ptr_distinct: assert property (@(posedge clk) disable iff (reset_i)
		(ptr.rff_pt != ptr.w_pt) && (ptr.w_pt != ptr.rup_pt) && (ptr.rff_pt != ptr.rup_pt))
		else $error("Activation pointers overlap");
endmodule

/* logic/act_mem_ctrl.sv */
`timescale 1ns/1ps

module act_mem_ctrl (
	input logic clk,
	input logic reset_i,
	cycle_if.sink cyc,
	ptr_if.sink ptr,
	input layer_ctrl_pkg::midx_t [layer_ctrl_pkg::Z-1:0] memory_index_i,
	output layer_ctrl_pkg::addr_t [layer_ctrl_pkg::ACT_COLL-1:0][layer_ctrl_pkg::Z-1:0] act_addr_o,
	output logic [layer_ctrl_pkg::ACT_COLL-1:0][layer_ctrl_pkg::Z-1:0] act_we_o
);
	import layer_ctrl_pkg::*;

	// Incoming data lags the cycle index by two clocks so writes use the d2 copy
	addr_t w_addr; // Same cell for every memory of the written collection
	logic data_clk; // Previous layer delivers a word on this clock
	logic [PART_W-1:0] part_sel; // Part being filled on this clock

	assign w_addr = cyc.cycle_index_d2[PART_W +: ADDR_W]; // Drops the part bits
	assign data_clk = cyc.cycle_index_d2 < cidx_t'(WRITE_CLKS);
	assign part_sel = cyc.cycle_index_d2[PART_W-1:0];

	for (genvar c = 0; c < ACT_COLL; c++)
	begin : g_coll
		logic is_w; // This collection is the one being filled

		assign is_w = (ptr.w_pt == act_pt_t'(c));

		for (genvar m = 0; m < Z; m++)
		begin : g_mem
			// Memories of one part share a slot and parts take turns clock by clock
			assign act_we_o[c][m] = is_w && data_clk && !reset_i
				&& (part_sel == PART_W'(m / (Z / FO)));

			// Collections not written are read at the interleaved cell
			assign act_addr_o[c][m] = is_w ? w_addr : memory_index_i[m][MIDX_W-1 -: ADDR_W];
		end

		// A write must never land in a collection that feed-forward or update reads
		a_we_only_w: assert property (@(posedge clk) disable iff (reset_i)
			(|act_we_o[c]) |-> ((ptr.rff_pt != act_pt_t'(c)) && (ptr.rup_pt != act_pt_t'(c))))
			else $error("Activation write outside the write collection");
	end
endmodule

/* logic/delta_mem_ctrl.sv */
`timescale 1ns/1ps

module delta_mem_ctrl (
	input logic clk,
	input logic reset_i,
	cycle_if.sink cyc,
	ptr_if.sink ptr,
	input layer_ctrl_pkg::midx_t [layer_ctrl_pkg::Z-1:0] memory_index_i,
	output layer_ctrl_pkg::addr_t [layer_ctrl_pkg::DM_COLL-1:0][layer_ctrl_pkg::Z-1:0] d_addr_a_o,
	output logic [layer_ctrl_pkg::DM_COLL-1:0][layer_ctrl_pkg::Z-1:0] d_we_a_o,
	output layer_ctrl_pkg::addr_t [layer_ctrl_pkg::DM_COLL-1:0][layer_ctrl_pkg::Z-1:0] d_addr_b_o,
	output logic [layer_ctrl_pkg::DM_COLL-1:0][layer_ctrl_pkg::Z-1:0] d_we_b_o
);
	import layer_ctrl_pkg::*;

	typedef addr_t [Z-1:0] addr_vec_t; // One address per memory of a collection

	addr_vec_t intl_addr; // Interleaved cells for the accumulating collection
	addr_vec_t intl_addr_d1;
	addr_vec_t seq_addr; // Cells in order for the collection read by the previous layer
	addr_vec_t seq_addr_d1;
	logic a_window; // Port A write-back slots of the read-modify-write
	logic b_window; // Port B clearing slots
	logic [PART_W-1:0] b_part; // Part cleared on this clock

	assign a_window = (cyc.cycle_index >= cidx_t'(1)) && (cyc.cycle_index <= cidx_t'(WRITE_CLKS));
	assign b_window = cyc.cycle_index_d1 < cidx_t'(CPC - 2);
	assign b_part = cyc.cycle_index_d1[PART_W-1:0];

	for (genvar m = 0; m < Z; m++)
	begin : g_raw
		assign intl_addr[m] = memory_index_i[m][MIDX_W-1 -: ADDR_W];
		assign seq_addr[m] = cyc.cycle_index[PART_W +: ADDR_W]; // Same cell in every memory
	end

	// Write-back lands one clock after the read of the same cell
	stage_delay #(.T(addr_vec_t), .DEPTH(1)) u_intl_d1 (
		.clk(clk),
		.reset_i(reset_i),
		.d_i(intl_addr),
		.q_o(intl_addr_d1)
	);

	// Clearing follows the sequential read one clock behind
	stage_delay #(.T(addr_vec_t), .DEPTH(1)) u_seq_d1 (
		.clk(clk),
		.reset_i(reset_i),
		.d_i(seq_addr),
		.q_o(seq_addr_d1)
	);

	for (genvar c = 0; c < DM_COLL; c++)
	begin : g_coll
		logic is_rd; // Collection read for back-propagation this cycle

		assign is_rd = (ptr.d_rbp_pt == 1'(c));

		// Read side reads on A and zeroes on B so it starts clean for its next turn
		assign d_addr_a_o[c] = is_rd ? seq_addr : intl_addr_d1;
		assign d_addr_b_o[c] = is_rd ? seq_addr_d1 : intl_addr;

		for (genvar m = 0; m < Z; m++)
		begin : g_mem
			assign d_we_a_o[c][m] = !is_rd && a_window && !reset_i; // Whole collection accumulates
			assign d_we_b_o[c][m] = is_rd && b_window && !reset_i
				&& (b_part == PART_W'(m / (Z / FO))); // Cleared part by part
		end

		// Write-back targets a cell read one clock earlier, so neither clock may see the read side
		a_no_a_write_rd: assert property (@(posedge clk) disable iff (reset_i)
			(|d_we_a_o[c]) |-> ((ptr.d_rbp_pt != 1'(c)) && ($past(ptr.d_rbp_pt) != 1'(c))))
			else $error("Delta port A writes the read collection");
	end
endmodule

/* logic/weight_mem_ctrl.sv */
`timescale 1ns/1ps

module weight_mem_ctrl (
	input logic clk,
	input logic reset_i,
	cycle_if.sink cyc,
	output logic [layer_ctrl_pkg::Z-1:0] w_we_o,
	output layer_ctrl_pkg::waddr_t w_raddr_o,
	output layer_ctrl_pkg::waddr_t w_waddr_o
);
	import layer_ctrl_pkg::*;

	logic wb_window; // Clocks on which an updated weight comes back
	waddr_t raddr; // Every weight memory reads the same cell

	assign wb_window = (cyc.cycle_index >= cidx_t'(1)) && (cyc.cycle_index <= cidx_t'(CPC - 2));
	assign raddr = cyc.cycle_index[WADDR_W-1:0]; // Top index bit only covers the pipeline tail

	assign w_we_o = {Z{wb_window && !reset_i}}; // All Z memories update together
	assign w_raddr_o = raddr;

	// The update takes one clock so the written cell is the one read just before
	stage_delay #(.T(waddr_t), .DEPTH(1)) u_waddr_d1 (
		.clk(clk),
		.reset_i(reset_i),
		.d_i(raddr),
		.q_o(w_waddr_o)
	);
endmodule

/* logic/layer_ctrl_top.sv */
`timescale 1ns/1ps

module layer_ctrl_top (
	input logic clk,
	input logic reset_i,
	input layer_ctrl_pkg::midx_t [layer_ctrl_pkg::Z-1:0] memory_index_i,
	output layer_ctrl_pkg::cidx_t cycle_index_o,
	output layer_ctrl_pkg::act_pt_t rff_pt_o,
	output layer_ctrl_pkg::act_pt_t rup_pt_o,
	output logic d_rbp_pt_o,
	output layer_ctrl_pkg::addr_t [layer_ctrl_pkg::ACT_COLL-1:0][layer_ctrl_pkg::Z-1:0] act_addr_o,
	output logic [layer_ctrl_pkg::ACT_COLL-1:0][layer_ctrl_pkg::Z-1:0] act_we_o,
	output layer_ctrl_pkg::addr_t [layer_ctrl_pkg::DM_COLL-1:0][layer_ctrl_pkg::Z-1:0] d_addr_a_o,
	output logic [layer_ctrl_pkg::DM_COLL-1:0][layer_ctrl_pkg::Z-1:0] d_we_a_o,
	output layer_ctrl_pkg::addr_t [layer_ctrl_pkg::DM_COLL-1:0][layer_ctrl_pkg::Z-1:0] d_addr_b_o,
	output logic [layer_ctrl_pkg::DM_COLL-1:0][layer_ctrl_pkg::Z-1:0] d_we_b_o,
	output logic [layer_ctrl_pkg::Z-1:0] w_we_o,
	output layer_ctrl_pkg::waddr_t w_raddr_o,
	output layer_ctrl_pkg::waddr_t w_waddr_o
);

	cycle_if cyc_bus (); // Cycle position fanned out to all controllers
	ptr_if ptr_bus (); // Collection pointers for the memory controllers

	cycle_sequencer u_seq (
		.clk(clk),
		.reset_i(reset_i),
		.cyc(cyc_bus.source),
		.cycle_index_o(cycle_index_o)
	);

	collection_pointers u_ptrs (
		.clk(clk),
		.reset_i(reset_i),
		.cyc(cyc_bus.sink),
		.ptr(ptr_bus.source),
		.rff_pt_o(rff_pt_o),
		.rup_pt_o(rup_pt_o)
	);

	// Sigmoid-prime memories share these enables and addresses
	act_mem_ctrl u_act (
		.clk(clk),
		.reset_i(reset_i),
		.cyc(cyc_bus.sink),
		.ptr(ptr_bus.sink),
		.memory_index_i(memory_index_i),
		.act_addr_o(act_addr_o),
		.act_we_o(act_we_o)
	);

	delta_mem_ctrl u_delta (
		.clk(clk),
		.reset_i(reset_i),
		.cyc(cyc_bus.sink),
		.ptr(ptr_bus.sink),
		.memory_index_i(memory_index_i),
		.d_addr_a_o(d_addr_a_o),
		.d_we_a_o(d_we_a_o),
		.d_addr_b_o(d_addr_b_o),
		.d_we_b_o(d_we_b_o)
	);

	weight_mem_ctrl u_weight (
		.clk(clk),
		.reset_i(reset_i),
		.cyc(cyc_bus.sink),
		.w_we_o(w_we_o),
		.w_raddr_o(w_raddr_o),
		.w_waddr_o(w_waddr_o)
	);

	assign d_rbp_pt_o = ptr_bus.d_rbp_pt; // Delta read pointer goes out undelayed
endmodule

/* test/layer_ctrl_tb.sv */
`timescale 1ns/1ps

module layer_ctrl_tb;
	import layer_ctrl_pkg::*;

	localparam int COLS = 8; // Test, reset clocks, random flag, index word, rff, w, rup, d_rbp
	localparam int MAX_ROWS = 64;

	logic clk;
	logic reset_i;
	midx_t [Z-1:0] memory_index_i;
	cidx_t cycle_index_o;
	act_pt_t rff_pt_o;
	act_pt_t rup_pt_o;
	logic d_rbp_pt_o;
	addr_t [ACT_COLL-1:0][Z-1:0] act_addr_o;
	logic [ACT_COLL-1:0][Z-1:0] act_we_o;
	addr_t [DM_COLL-1:0][Z-1:0] d_addr_a_o;
	logic [DM_COLL-1:0][Z-1:0] d_we_a_o;
	addr_t [DM_COLL-1:0][Z-1:0] d_addr_b_o;
	logic [DM_COLL-1:0][Z-1:0] d_we_b_o;
	logic [Z-1:0] w_we_o;
	waddr_t w_raddr_o;
	waddr_t w_waddr_o;

	logic [15:0] cases [COLS*MAX_ROWS]; // Flat copy of the cases file, COLS words per row
	logic [31:0] rng_state;
	int row_rff, row_w, row_rup, row_d; // Pointers the current row expects inside the DUT
	int m_idx, m_d1, m_d2, seq_d1, raddr_d1, prev_rff, prev_rup;
	int intl_d1 [Z]; // Interleaved cells seen one clock earlier
	int checks, test_errs, total_errs, tests;
	logic timed_out; // Set once a wait gave up

	layer_ctrl_top uut (
		.clk(clk),
		.reset_i(reset_i),
		.memory_index_i(memory_index_i),
		.cycle_index_o(cycle_index_o),
		.rff_pt_o(rff_pt_o),
		.rup_pt_o(rup_pt_o),
		.d_rbp_pt_o(d_rbp_pt_o),
		.act_addr_o(act_addr_o),
		.act_we_o(act_we_o),
		.d_addr_a_o(d_addr_a_o),
		.d_we_a_o(d_we_a_o),
		.d_addr_b_o(d_addr_b_o),
		.d_we_b_o(d_we_b_o),
		.w_we_o(w_we_o),
		.w_raddr_o(w_raddr_o),
		.w_waddr_o(w_waddr_o)
	);

	always #4 clk = ~clk; // 8 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Cell of a memory for a given clock of the cycle, parts share one cell
	function automatic int cell_of(input int idx);
		return (idx / FO) % (P / Z);
	endfunction

	// Reference model state, it moves on the same edge as the DUT registers
	always @(posedge clk)
	begin
		if (reset_i)
		begin
			m_idx <= 0;
			m_d1 <= 0;
			m_d2 <= 0;
			seq_d1 <= 0;
			raddr_d1 <= 0;
			prev_rff <= 0;
			prev_rup <= 0;
			for (int m = 0; m < Z; m++)
				intl_d1[m] <= 0;
		end
		else
		begin
			m_idx <= (m_idx == CPC - 1) ? 0 : m_idx + 1; // Wraps after CPC clocks
			m_d1 <= m_idx;
			m_d2 <= m_d1;
			seq_d1 <= cell_of(m_idx);
			raddr_d1 <= m_idx % (1 << WADDR_W);
			prev_rff <= row_rff; // Late copies seen by the read multiplexers
			prev_rup <= row_rup;
			for (int m = 0; m < Z; m++)
				intl_d1[m] <= int'(memory_index_i[m]) >> (MIDX_W - ADDR_W);
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual, input int expected);
		checks++;
		if (actual !== 32'(expected))
		begin
			test_errs++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// Steps to the next falling edge, gives up after three clock changes
	task automatic wait_fall();
		int edges;
		edges = 0;
		do
		begin
			@(clk);
			edges++;
		end
		while (clk !== 1'b0 && edges < 3);
		if (clk !== 1'b0)
		begin
			$display("Timed out waiting for a falling clock edge");
			timed_out = 1'b1; // Remaining rows are skipped
		end
	endtask

	task automatic check_quiet();
		check_value("act_we_o", 32'(act_we_o), 0); // Nothing may write while reset is high
		check_value("d_we_a_o", 32'(d_we_a_o), 0);
		check_value("d_we_b_o", 32'(d_we_b_o), 0);
		check_value("w_we_o", 32'(w_we_o), 0);
	endtask

	task automatic hold_reset(input int clocks);
		reset_i = 1'b1;
		for (int i = 0; i < clocks && !timed_out; i++)
		begin
			#2;
			check_quiet();
			wait_fall();
		end
		reset_i = 1'b0;
	endtask

	task automatic check_slot();
		int we;
		int addr;
		int a_we, a_addr, b_we, b_addr;
		check_value("cycle_index_o", 32'(cycle_index_o), m_idx);
		check_value("rff_pt_o", 32'(rff_pt_o), prev_rff);
		check_value("rup_pt_o", 32'(rup_pt_o), prev_rup);
		check_value("d_rbp_pt_o", 32'(d_rbp_pt_o), row_d);
		for (int c = 0; c < ACT_COLL; c++)
			for (int m = 0; m < Z; m++)
			begin
				// Data of the previous layer arrives two clocks behind the index
				we = (c == row_w && m_d2 < WRITE_CLKS && m_d2 % FO == m / (Z / FO)) ? 1 : 0;
				addr = (c == row_w) ? cell_of(m_d2)
					: int'(memory_index_i[m]) >> (MIDX_W - ADDR_W);
				check_value($sformatf("act_we_o[%0d][%0d]", c, m), 32'(act_we_o[c][m]), we);
				check_value($sformatf("act_addr_o[%0d][%0d]", c, m), 32'(act_addr_o[c][m]), addr);
			end
		for (int c = 0; c < DM_COLL; c++)
			for (int m = 0; m < Z; m++)
			begin
				if (c == row_d)
				begin
					a_we = 0; // Read collection, port A only reads in order
					a_addr = cell_of(m_idx);
					b_we = (m_d1 < CPC - 2 && m_d1 % FO == m / (Z / FO)) ? 1 : 0;
					b_addr = seq_d1;
				end
				else
				begin
					a_we = (m_idx >= 1 && m_idx <= WRITE_CLKS) ? 1 : 0;
					a_addr = intl_d1[m]; // Write-back of the cell read one clock before
					b_we = 0;
					b_addr = int'(memory_index_i[m]) >> (MIDX_W - ADDR_W);
				end
				check_value($sformatf("d_we_a_o[%0d][%0d]", c, m), 32'(d_we_a_o[c][m]), a_we);
				check_value($sformatf("d_addr_a_o[%0d][%0d]", c, m), 32'(d_addr_a_o[c][m]), a_addr);
				check_value($sformatf("d_we_b_o[%0d][%0d]", c, m), 32'(d_we_b_o[c][m]), b_we);
				check_value($sformatf("d_addr_b_o[%0d][%0d]", c, m), 32'(d_addr_b_o[c][m]), b_addr);
			end
		we = (m_idx >= 1 && m_idx <= CPC - 2) ? 1 : 0;
		for (int m = 0; m < Z; m++)
			check_value($sformatf("w_we_o[%0d]", m), 32'(w_we_o[m]), we);
		check_value("w_raddr_o", 32'(w_raddr_o), m_idx % (1 << WADDR_W));
		check_value("w_waddr_o", 32'(w_waddr_o), raddr_d1);
	endtask

	initial
	begin
		int rows;
		int base;
		clk = 1'b0;
		reset_i = 1'b1;
		memory_index_i = '0;
		rng_state = 32'h3b6a8004;
		checks = 0;
		test_errs = 0;
		total_errs = 0;
		tests = 0;
		timed_out = 1'b0;
		$readmemh("test/layer_ctrl_cases.txt", cases);
		rows = 0;
		while (rows < MAX_ROWS && !$isunknown(cases[rows*COLS]) && cases[rows*COLS] != '0)
			rows++;
		if (rows == 0)
		begin
			$display("The cases file test/layer_ctrl_cases.txt holds no rows");
			total_errs++;
		end
		for (int r = 0; r < rows && !timed_out; r++)
		begin
			base = r * COLS;
			if (cases[base+1] != '0)
				hold_reset(int'(cases[base+1])); // Ends on a falling edge with reset low
			if (cases[base+2] != '0)
			begin
				rng_state = xorshift32(rng_state);
				memory_index_i = rng_state[15:0];
			end
			else
				memory_index_i = cases[base+3];
			row_rff = int'(cases[base+4]);
			row_w = int'(cases[base+5]);
			row_rup = int'(cases[base+6]);
			row_d = int'(cases[base+7]);
			#2;
			check_slot();
			wait_fall();
			if (r == rows - 1 || cases[base+COLS] != cases[base])
			begin
				$display("Test %0d finished with %0d mismatches", cases[base], test_errs);
				total_errs += test_errs;
				test_errs = 0;
				tests++;
			end
		end
		$display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, total_errs);
		if (total_errs == 0 && !timed_out)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end
endmodule

/* test/layer_ctrl_cases.txt */
// test  reset_clocks  random  index_word  rff  w  rup  d_rbp
// One row per clock, index_word nibble m is the index of memory m
1 4 0 c840 0 1 2 0
1 0 0 d951 0 1 2 0
1 0 0 ea62 0 1 2 0
1 0 0 fb73 0 1 2 0
1 0 0 08c4 0 1 2 0
1 0 0 19d5 0 1 2 0
1 0 0 2ae6 0 1 2 0
1 0 0 3bf7 0 1 2 0
1 0 0 4c08 0 1 2 0
1 0 0 5d19 0 1 2 0
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
2 0 1 0000 1 2 0 1
3 0 1 0000 2 0 1 0
3 0 1 0000 2 0 1 0
3 0 1 0000 2 0 1 0
3 0 1 0000 2 0 1 0
3 0 1 0000 2 0 1 0
4 3 0 7f3b 0 1 2 0
4 0 0 6e2a 0 1 2 0
4 0 0 9c15 0 1 2 0
4 0 0 a4d0 0 1 2 0
4 0 0 31f8 0 1 2 0

/* project.f */
logic/layer_ctrl_pkg.sv
logic/ctrl_ifs.sv
logic/stage_delay.sv
logic/cycle_sequencer.sv
logic/collection_pointers.sv
logic/act_mem_ctrl.sv
logic/delta_mem_ctrl.sv
logic/weight_mem_ctrl.sv
logic/layer_ctrl_top.sv
test/layer_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the layer controller testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -f project.f \
	--top-module layer_ctrl_tb -o layer_ctrl_sim; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/layer_ctrl_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
